// File: mem_pkg.sv
// Shared memory constants; byte address is word aligned and wraps modulo mem_depth words
package mem_pkg;

  // Bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;

  // Byte lanes in one word
  localparam int byte_width = 8;
  localparam int strb_width = data_width / byte_width;

  // Word array size
  localparam int mem_depth = 1024;
  localparam int index_width = $clog2(mem_depth);  // 10 bits

  // Word index starts above the byte offset bits
  localparam int index_lsb = $clog2(strb_width);  // Address bits 11:2

  // Owner codes for response routing
  localparam logic port_fetch = 1'b0;
  localparam logic port_lsu = 1'b1;

endpackage

// File: sram.sv
// One-cycle latency word memory; a read beats a same-cycle write and the array has no reset
`timescale 1ns/1ps

module sram (
  input  logic                           clk,
  input  logic                           rst,
  // Read request
  input  logic                           rd_req_valid,
  input  logic [mem_pkg::addr_width-1:0] addr,
  // Write request
  input  logic                           wt_req_valid,
  input  logic [mem_pkg::addr_width-1:0] waddr,
  input  logic [mem_pkg::data_width-1:0] wdata,
  input  logic [mem_pkg::strb_width-1:0] wmask,
  // Responses
  output logic [mem_pkg::data_width-1:0] data_out,
  output logic                           rd_res_valid,
  output logic                           wt_res_valid
);
  import mem_pkg::*;

  logic [data_width-1:0]  mem_array [mem_depth];

  // Request registered at the edge
  logic                   rd_q;
  logic                   wt_q;
  logic [index_width-1:0] rd_idx_q;
  logic [index_width-1:0] wt_idx_q;
  logic [data_width-1:0]  wdata_q;
  logic [strb_width-1:0]  wmask_q;

  logic                   wt_fire;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_q     <= 1'b0;
      wt_q     <= 1'b0;
      rd_idx_q <= '0;
      wt_idx_q <= '0;
      wdata_q  <= '0;
      wmask_q  <= '0;
    end else begin
      rd_q     <= rd_req_valid;
      wt_q     <= wt_req_valid;
      rd_idx_q <= addr[index_lsb +: index_width];  // Upper bits wrap
      wt_idx_q <= waddr[index_lsb +: index_width];
      wdata_q  <= wdata;
      wmask_q  <= wmask;
    end
  end

  // A registered read takes the cycle and the write is lost
  assign wt_fire = wt_q & ~rd_q;

  // Byte merge into the array at the end of the response cycle
  always_ff @(posedge clk) begin
    if (wt_fire) begin
      for (int i = 0; i < strb_width; i++) begin
        if (wmask_q[i]) begin
          mem_array[wt_idx_q][i*byte_width +: byte_width] <=
            wdata_q[i*byte_width +: byte_width];
        end
      end
    end
  end

  // Read data valid only with its strobe
  assign data_out     = rd_q ? mem_array[rd_idx_q] : '0;
  assign rd_res_valid = rd_q;
  assign wt_res_valid = wt_fire;  // Pulses in the cycle the array is written

endmodule

// File: mem_arbiter.sv
// Fixed-priority arbiter, load/store first; requesters hold each request until its response
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                           clk,
  input  logic                           rst,
  // Instruction fetch port
  input  logic                           if_req,
  input  logic [mem_pkg::addr_width-1:0] if_addr,
  output logic [mem_pkg::data_width-1:0] if_rdata,
  output logic                           if_rvalid,
  // Load/store port
  input  logic                           ls_rd_req,
  input  logic                           ls_wt_req,
  input  logic [mem_pkg::addr_width-1:0] ls_addr,
  input  logic [mem_pkg::data_width-1:0] ls_wdata,
  input  logic [mem_pkg::strb_width-1:0] ls_wstrb,
  output logic [mem_pkg::data_width-1:0] ls_rdata,
  output logic                           ls_rvalid,
  output logic                           ls_wvalid,
  // SRAM request side
  output logic                           rd_req_valid,
  output logic                           wt_req_valid,
  output logic [mem_pkg::addr_width-1:0] addr,
  output logic [mem_pkg::addr_width-1:0] waddr,
  output logic [mem_pkg::data_width-1:0] wdata,
  output logic [mem_pkg::strb_width-1:0] wmask,
  // SRAM response side
  input  logic [mem_pkg::data_width-1:0] data_out,
  input  logic                           rd_res_valid,
  input  logic                           wt_res_valid
);
  import mem_pkg::*;

  // One outstanding request per port
  logic if_pend;
  logic ls_pend;

  logic if_elig;
  logic ls_elig;
  logic grant_if;
  logic grant_ls;

  // Issuer of last cycle's grant
  logic owner_q;

  logic if_own;
  logic ls_own;

  assign if_elig = if_req & ~if_pend;
  assign ls_elig = (ls_rd_req | ls_wt_req) & ~ls_pend;

  // Load/store first, fetch waits one cycle on conflict
  assign grant_ls = ls_elig;
  assign grant_if = if_elig & ~ls_elig;

  // Forward the winner to the SRAM in the grant cycle
  assign rd_req_valid = grant_ls ? ls_rd_req : grant_if;
  assign wt_req_valid = grant_ls & ls_wt_req;
  assign addr         = grant_ls ? ls_addr : if_addr;
  assign waddr        = ls_addr;  // Only load/store writes
  assign wdata        = ls_wdata;
  assign wmask        = wt_req_valid ? ls_wstrb : '0;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      owner_q <= port_fetch;
    end else if (grant_ls || grant_if) begin
      owner_q <= grant_ls ? port_lsu : port_fetch;
    end
  end

  assign if_own = (owner_q == port_fetch);
  assign ls_own = (owner_q == port_lsu);

  // Response goes back to its issuer only
  assign if_rvalid = rd_res_valid & if_own;
  assign ls_rvalid = rd_res_valid & ls_own;
  assign ls_wvalid = wt_res_valid & ls_own;

  assign if_rdata = if_rvalid ? data_out : '0;  // Zero to the other port
  assign ls_rdata = ls_rvalid ? data_out : '0;

  // Set on grant, cleared by the port's own response
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      if_pend <= 1'b0;
    end else if (grant_if) begin
      if_pend <= 1'b1;
    end else if (if_rvalid) begin
      if_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ls_pend <= 1'b0;
    end else if (grant_ls) begin
      ls_pend <= 1'b1;
    end else if (ls_rvalid || ls_wvalid) begin
      ls_pend <= 1'b0;
    end
  end

endmodule

// File: mem_top.sv
// Memory subsystem top; fetch reads words only and load/store never raises read and write together
`timescale 1ns/1ps

module mem_top (
  input  logic                           clk,
  input  logic                           rst,
  // Instruction fetch
  input  logic                           if_req,
  input  logic [mem_pkg::addr_width-1:0] if_addr,
  output logic [mem_pkg::data_width-1:0] if_rdata,
  output logic                           if_rvalid,
  // Load/store
  input  logic                           ls_rd_req,
  input  logic                           ls_wt_req,
  input  logic [mem_pkg::addr_width-1:0] ls_addr,
  input  logic [mem_pkg::data_width-1:0] ls_wdata,
  input  logic [mem_pkg::strb_width-1:0] ls_wstrb,
  output logic [mem_pkg::data_width-1:0] ls_rdata,
  output logic                           ls_rvalid,
  output logic                           ls_wvalid
);
  import mem_pkg::*;

  // Arbiter to SRAM
  logic                  rd_req_valid;
  logic                  wt_req_valid;
  logic [addr_width-1:0] addr;
  logic [addr_width-1:0] waddr;
  logic [data_width-1:0] wdata;
  logic [strb_width-1:0] wmask;

  // SRAM to arbiter
  logic [data_width-1:0] data_out;
  logic                  rd_res_valid;
  logic                  wt_res_valid;

  mem_arbiter mem_arbiter_inst (
    .clk          (clk),
    .rst          (rst),
    .if_req       (if_req),
    .if_addr      (if_addr),
    .if_rdata     (if_rdata),
    .if_rvalid    (if_rvalid),
    .ls_rd_req    (ls_rd_req),
    .ls_wt_req    (ls_wt_req),
    .ls_addr      (ls_addr),
    .ls_wdata     (ls_wdata),
    .ls_wstrb     (ls_wstrb),
    .ls_rdata     (ls_rdata),
    .ls_rvalid    (ls_rvalid),
    .ls_wvalid    (ls_wvalid),
    .rd_req_valid (rd_req_valid),
    .wt_req_valid (wt_req_valid),
    .addr         (addr),
    .waddr        (waddr),
    .wdata        (wdata),
    .wmask        (wmask),
    .data_out     (data_out),
    .rd_res_valid (rd_res_valid),
    .wt_res_valid (wt_res_valid)
  );

  sram sram_inst (
    .clk          (clk),
    .rst          (rst),
    .rd_req_valid (rd_req_valid),
    .addr         (addr),
    .wt_req_valid (wt_req_valid),
    .waddr        (waddr),
    .wdata        (wdata),
    .wmask        (wmask),
    .data_out     (data_out),
    .rd_res_valid (rd_res_valid),
    .wt_res_valid (wt_res_valid)
  );

endmodule

// File: mem_top_sva.sv
// Arbiter checks sampled at the rising edge; all properties are off while rst is high
`timescale 1ns/1ps

module mem_top_sva (
  input logic clk,
  input logic rst,
  input logic rd_req_valid,
  input logic wt_req_valid,
  input logic if_rvalid,
  input logic ls_rvalid,
  input logic ls_wvalid,
  input logic grant_if,
  input logic grant_ls
);

  // SRAM never sees a read and a write in one cycle
  one_sram_strobe: assert property (@(posedge clk) disable iff (rst)
    !(rd_req_valid && wt_req_valid))
    else $error("read and write strobes high together");

  read_resp_excl: assert property (@(posedge clk) disable iff (rst)
    !(if_rvalid && ls_rvalid))
    else $error("both ports received read data");

  // Every issued request comes back to exactly one port
  resp_follows_req: assert property (@(posedge clk) disable iff (rst)
    (rd_req_valid || wt_req_valid) |=> $onehot({if_rvalid, ls_rvalid, ls_wvalid}))
    else $error("request without exactly one port response");

  // A held request is not issued again while its response is pending
  no_grant_if_pend: assert property (@(posedge clk) disable iff (rst)
    grant_if |=> !grant_if)
    else $error("fetch granted while pending");

  no_grant_ls_pend: assert property (@(posedge clk) disable iff (rst)
    grant_ls |=> !grant_ls)
    else $error("load/store granted while pending");

  // Response lands on the port that was granted
  fetch_route: assert property (@(posedge clk) disable iff (rst)
    grant_if |=> if_rvalid)
    else $error("fetch grant not answered on the fetch port");

  lsu_route: assert property (@(posedge clk) disable iff (rst)
    grant_ls |=> (ls_rvalid || ls_wvalid))
    else $error("load/store grant not answered on the load/store port");

endmodule

bind mem_arbiter mem_top_sva mem_top_sva_inst (
  .clk          (clk),
  .rst          (rst),
  .rd_req_valid (rd_req_valid),
  .wt_req_valid (wt_req_valid),
  .if_rvalid    (if_rvalid),
  .ls_rvalid    (ls_rvalid),
  .ls_wvalid    (ls_wvalid),
  .grant_if     (grant_if),
  .grant_ls     (grant_ls)
);

// File: tb_mem_top.sv
// Steps come from mem_golden.txt in the run directory; each step waits for both ports before the next
`timescale 1ns/1ps

module tb_mem_top;
  import mem_pkg::*;

  // Load/store kinds in the golden file
  localparam logic [1:0] kind_none  = 2'd0;
  localparam logic [1:0] kind_read  = 2'd1;
  localparam logic [1:0] kind_write = 2'd2;

  localparam int resp_edges = 2;  // Falling edges from drive to an uncontested response

  logic                  clk;
  logic                  rst;
  logic                  if_req;
  logic [addr_width-1:0] if_addr;
  logic [data_width-1:0] if_rdata;
  logic                  if_rvalid;
  logic                  ls_rd_req;
  logic                  ls_wt_req;
  logic [addr_width-1:0] ls_addr;
  logic [data_width-1:0] ls_wdata;
  logic [strb_width-1:0] ls_wstrb;
  logic [data_width-1:0] ls_rdata;
  logic                  ls_rvalid;
  logic                  ls_wvalid;

  // Golden steps
  logic                  g_if_valid [$];
  logic [addr_width-1:0] g_if_addr [$];
  logic [data_width-1:0] g_if_exp [$];
  logic [1:0]            g_ls_kind [$];
  logic [addr_width-1:0] g_ls_addr [$];
  logic [data_width-1:0] g_ls_wdata [$];
  logic [strb_width-1:0] g_ls_wstrb [$];
  logic [data_width-1:0] g_ls_exp [$];

  int n_steps;
  int cycle_count;
  int cycle_limit;

  mem_top mem_top_inst (
    .clk       (clk),
    .rst       (rst),
    .if_req    (if_req),
    .if_addr   (if_addr),
    .if_rdata  (if_rdata),
    .if_rvalid (if_rvalid),
    .ls_rd_req (ls_rd_req),
    .ls_wt_req (ls_wt_req),
    .ls_addr   (ls_addr),
    .ls_wdata  (ls_wdata),
    .ls_wstrb  (ls_wstrb),
    .ls_rdata  (ls_rdata),
    .ls_rvalid (ls_rvalid),
    .ls_wvalid (ls_wvalid)
  );

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [data_width-1:0] actual,
                            input logic [data_width-1:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_strobe(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic load_golden();
    int                    fd;
    int                    cnt;
    string                 line;
    logic                  if_v;
    logic [addr_width-1:0] ia;
    logic [data_width-1:0] ie;
    logic [1:0]            k;
    logic [addr_width-1:0] la;
    logic [data_width-1:0] wd;
    logic [strb_width-1:0] ws;
    logic [data_width-1:0] le;
    fd = $fopen("mem_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open mem_golden.txt for reading");
      abort_run();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h", if_v, ia, ie, k, la, wd, ws, le);
          if (cnt == 8) begin  // Comment and blank lines fall through
            g_if_valid.push_back(if_v);
            g_if_addr.push_back(ia);
            g_if_exp.push_back(ie);
            g_ls_kind.push_back(k);
            g_ls_addr.push_back(la);
            g_ls_wdata.push_back(wd);
            g_ls_wstrb.push_back(ws);
            g_ls_exp.push_back(le);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_idle();
    repeat (4) begin
      @(negedge clk);
      check_strobe("if_rvalid", if_rvalid, 1'b0);
      check_strobe("ls_rvalid", ls_rvalid, 1'b0);
      check_strobe("ls_wvalid", ls_wvalid, 1'b0);
    end
  endtask

  task automatic serve_fetch(input logic valid, input logic [addr_width-1:0] a,
                             input logic [data_width-1:0] exp_data, input int lat);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    if (valid) begin
      if_addr = a;
      if_req  = 1'b1;
      while (!seen) begin
        @(negedge clk);
        n++;
        check_strobe("if_rvalid", if_rvalid, n == lat);
        if (if_rvalid) begin
          seen = 1'b1;
          check_data("if_rdata", if_rdata, exp_data);
          check_data("ls_rdata", ls_rdata, '0);  // Other port stays quiet
        end
      end
      @(posedge clk);
      #1;
      if_req = 1'b0;
    end
  endtask

  task automatic serve_lsu(input logic [1:0] kind, input logic [addr_width-1:0] a,
                           input logic [data_width-1:0] wd, input logic [strb_width-1:0] ws,
                           input logic [data_width-1:0] exp_data);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    if (kind != kind_none) begin
      ls_addr   = a;
      ls_wdata  = wd;
      ls_wstrb  = ws;
      ls_rd_req = (kind == kind_read);
      ls_wt_req = (kind == kind_write);
      while (!seen) begin
        @(negedge clk);
        n++;
        check_strobe("ls_rvalid", ls_rvalid, (kind == kind_read) && (n == resp_edges));
        check_strobe("ls_wvalid", ls_wvalid, (kind == kind_write) && (n == resp_edges));
        if (ls_rvalid || ls_wvalid) begin
          seen = 1'b1;
          check_data("ls_rdata", ls_rdata, exp_data);  // Zero in the file for writes
          check_strobe("if_rvalid", if_rvalid, 1'b0);
        end
      end
      @(posedge clk);
      #1;
      ls_rd_req = 1'b0;
      ls_wt_req = 1'b0;
    end
  endtask

  task automatic run_step(input int s);
    int fetch_lat;
    fetch_lat = (g_ls_kind[s] == kind_none) ? resp_edges : resp_edges + 1;  // Loses to load/store
    @(posedge clk);
    #1;
    fork
      serve_fetch(g_if_valid[s], g_if_addr[s], g_if_exp[s], fetch_lat);
      serve_lsu(g_ls_kind[s], g_ls_addr[s], g_ls_wdata[s], g_ls_wstrb[s], g_ls_exp[s]);
    join
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
      abort_run();
    end
  end

  initial begin
    rst         = 1'b1;
    if_req      = 1'b0;
    if_addr     = '0;
    ls_rd_req   = 1'b0;
    ls_wt_req   = 1'b0;
    ls_addr     = '0;
    ls_wdata    = '0;
    ls_wstrb    = '0;
    cycle_count = 0;
    cycle_limit = 0;
    load_golden();
    n_steps = g_if_valid.size();
    cycle_limit = 8 * n_steps + 50;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    check_idle();
    for (int s = 0; s < n_steps; s++) begin
      run_step(s);
    end
    if (n_steps == 0) begin
      $display("Golden file gave no steps");
      abort_run();
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// File: mem_golden.txt
# if_valid if_addr if_expected ls_kind(0 none,1 read,2 write) ls_addr ls_wdata ls_wstrb ls_expected
# All hex; load/store is served before fetch within a step
# Full-word writes and read back
0 00000000 00000000 2 00000000 11111111 f 00000000
0 00000000 00000000 1 00000000 00000000 0 11111111
0 00000000 00000000 2 00000004 22222222 f 00000000
0 00000000 00000000 2 00000008 33333333 f 00000000
0 00000000 00000000 2 0000000c 44444444 f 00000000
0 00000000 00000000 1 00000004 00000000 0 22222222
0 00000000 00000000 1 0000000c 00000000 0 44444444
0 00000000 00000000 2 00000ffc cafef00d f 00000000
0 00000000 00000000 1 00000ffc 00000000 0 cafef00d
0 00000000 00000000 2 00000010 a5a5a5a5 f 00000000
0 00000000 00000000 2 00000014 5a5a5a5a f 00000000
0 00000000 00000000 2 00000018 00000000 f 00000000
0 00000000 00000000 2 0000001c ffffffff f 00000000
# Byte enables
0 00000000 00000000 2 00000010 000000ee 1 00000000
0 00000000 00000000 1 00000010 00000000 0 a5a5a5ee
0 00000000 00000000 2 00000014 0000bb00 2 00000000
0 00000000 00000000 1 00000014 00000000 0 5a5abb5a
0 00000000 00000000 2 00000018 12345678 4 00000000
0 00000000 00000000 2 00000018 9abcdef0 8 00000000
0 00000000 00000000 1 00000018 00000000 0 9a340000
0 00000000 00000000 2 0000001c 00000000 5 00000000
0 00000000 00000000 1 0000001c 00000000 0 ff00ff00
0 00000000 00000000 2 0000001c 11223344 0 00000000
0 00000000 00000000 1 0000001c 00000000 0 ff00ff00
0 00000000 00000000 2 00000000 0000abcd 3 00000000
0 00000000 00000000 1 00000000 00000000 0 1111abcd
0 00000000 00000000 2 00000008 deadbeef 6 00000000
0 00000000 00000000 1 00000008 00000000 0 33adbe33
# Addresses wrap modulo the depth
0 00000000 00000000 1 00001000 00000000 0 1111abcd
0 00000000 00000000 2 00002004 0badf00d f 00000000
0 00000000 00000000 1 00000004 00000000 0 0badf00d
# Fetch alone, back to back
1 00000000 1111abcd 0 00000000 00000000 0 00000000
1 00000004 0badf00d 0 00000000 00000000 0 00000000
1 00000008 33adbe33 0 00000000 00000000 0 00000000
1 0000000c 44444444 0 00000000 00000000 0 00000000
1 00000010 a5a5a5ee 0 00000000 00000000 0 00000000
1 00000014 5a5abb5a 0 00000000 00000000 0 00000000
1 00000018 9a340000 0 00000000 00000000 0 00000000
1 0000001c ff00ff00 0 00000000 00000000 0 00000000
1 00000ffc cafef00d 0 00000000 00000000 0 00000000
# Contention between the two ports
1 00000020 deadbeef 2 00000020 deadbeef f 00000000
1 00000000 1111abcd 1 00000004 00000000 0 0badf00d
1 00000010 a577a5ee 2 00000010 00770000 4 00000000
1 00000024 87654321 2 00000024 87654321 f 00000000
1 00000024 87654321 1 00000020 00000000 0 deadbeef
1 00000008 33adbe33 2 0000000c 00000000 f 00000000
1 0000000c 00000000 1 00000008 00000000 0 33adbe33
1 0000001c ff00ffaa 2 0000001c 000000aa 1 00000000
1 0000001c ff00ffaa 1 0000001c 00000000 0 ff00ffaa
1 00001020 deadbeef 2 00000014 11111111 f 00000000
1 00000014 11111111 0 00000000 00000000 0 00000000
0 00000000 00000000 1 00000014 00000000 0 11111111
1 00000028 00c0ffee 2 00000028 00c0ffee f 00000000
1 00000004 0bad5555 2 00000004 55555555 3 00000000
1 00000004 0bad5555 1 00000028 00000000 0 00c0ffee

// File: files.f
mem_pkg.sv
sram.sv
mem_arbiter.sv
mem_top.sv
mem_top_sva.sv
tb_mem_top.sv
